// ==== common/oramCryptoPkg.sv ====
// ------------------------------
// Shared widths, vector types and
// config register addresses
// ------------------------------
`default_nettype none

package oramCryptoPkg;

	// ------------------------------
	// Widths
	// ------------------------------

	// Stream word coming from DRAM
	localparam int FlitWidth = 64;
	localparam int KeyWidth = 64;
	localparam int SeedWidth = 64;
	// Cipher works on two halves per round
	localparam int HalfWidth = SeedWidth / 2;
	// IV sits in the low bits of each header
	localparam int IvWidth = 32;
	localparam int BucketIdWidth = 8;
	localparam int ChunkIdWidth = 8;
	// Zero bits above the IV in a seed
	localparam int SeedPadWidth = SeedWidth - IvWidth - BucketIdWidth - ChunkIdWidth;
	localparam int CfgAddrWidth = 2;
	localparam int CfgDataWidth = 32;

	// ------------------------------
	// Vector types
	// ------------------------------

	typedef logic [FlitWidth-1:0] flitT;
	typedef logic [KeyWidth-1:0] keyT;
	typedef logic [SeedWidth-1:0] seedT;
	typedef logic [HalfWidth-1:0] halfT;
	typedef logic [IvWidth-1:0] ivT;
	typedef logic [BucketIdWidth-1:0] bucketIdT;
	typedef logic [ChunkIdWidth-1:0] chunkIdT;
	typedef logic [CfgAddrWidth-1:0] cfgAddrT;
	typedef logic [CfgDataWidth-1:0] cfgDataT;

	// Config register map
	localparam cfgAddrT CfgKeyLow = 2'd0;
	localparam cfgAddrT CfgKeyHigh = 2'd1;
	localparam cfgAddrT CfgControl = 2'd2;
	// Control register enable bit
	localparam int EnableBit = 0;

endpackage

`default_nettype wire

// ==== logic/cryptoConfig.sv ====
// ------------------------------
// Key and control registers
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module cryptoConfig (
	input wire logic Clock,
	input wire logic arstN,
	input wire logic CfgWrite,
	input wire oramCryptoPkg::cfgAddrT CfgAddr,
	input wire oramCryptoPkg::cfgDataT CfgData,
	output oramCryptoPkg::keyT Key,
	output logic Enable
);

	// Key halves, low then high
	oramCryptoPkg::cfgDataT keyLow;
	oramCryptoPkg::cfgDataT keyHigh;
	// Only bit 0 of control is implemented
	logic enableReg;

	// ------------------------------
	// Write decode
	// ------------------------------

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			keyLow <= '0;
			keyHigh <= '0;
			enableReg <= 1'b0;
		end else if (CfgWrite) begin
			case (CfgAddr)
				oramCryptoPkg::CfgKeyLow: keyLow <= CfgData;
				oramCryptoPkg::CfgKeyHigh: keyHigh <= CfgData;
				oramCryptoPkg::CfgControl: enableReg <= CfgData[oramCryptoPkg::EnableBit];
				// Address 3 unused, writes dropped
				default: ;
			endcase
		end
	end

	// Visible from the cycle after the write
	assign Key = {keyHigh, keyLow};
	assign Enable = enableReg;

endmodule

`default_nettype wire

// ==== logic/seedGen.sv ====
// ------------------------------
// Bucket and chunk tracking,
// IV capture and seed forming
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module seedGen #(
	parameter int BucketFlits = 4,
	parameter int PathBuckets = 3
) (
	input wire logic Clock,
	input wire logic arstN,
	input wire logic InValid,
	input wire oramCryptoPkg::flitT InData,
	output logic SeedValid,
	output oramCryptoPkg::seedT Seed,
	output oramCryptoPkg::flitT SeedFlit,
	output logic SeedIsHeader
);

	typedef enum logic {
		awaitHeader,
		inBucket
	} seedStateT;

	seedStateT state;
	// IV of the bucket in flight
	oramCryptoPkg::ivT ivReg;
	oramCryptoPkg::bucketIdT bucketId;
	// Next payload chunk, 1 to BucketFlits-1
	oramCryptoPkg::chunkIdT chunkId;

	logic isHeader;
	logic lastChunk;
	logic lastBucket;
	oramCryptoPkg::ivT curIv;
	oramCryptoPkg::chunkIdT curChunk;

	// First flit after a bucket ends is its header
	assign isHeader = (state == awaitHeader);
	assign lastChunk = (chunkId == oramCryptoPkg::chunkIdT'(BucketFlits - 1));
	assign lastBucket = (bucketId == oramCryptoPkg::bucketIdT'(PathBuckets - 1));

	// Header seeds take the IV straight off the wire
	assign curIv = isHeader ? InData[oramCryptoPkg::IvWidth-1:0] : ivReg;
	assign curChunk = isHeader ? '0 : chunkId;

	// ------------------------------
	// Position FSM
	// ------------------------------

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			state <= awaitHeader;
			ivReg <= '0;
			bucketId <= '0;
			chunkId <= '0;
		end else if (InValid) begin
			case (state)
				awaitHeader: begin
					ivReg <= InData[oramCryptoPkg::IvWidth-1:0];
					chunkId <= oramCryptoPkg::chunkIdT'(1);
					state <= inBucket;
				end
				inBucket: begin
					if (lastChunk) begin
						// Bucket done, wrap at path end
						bucketId <= lastBucket ? '0 : bucketId + 1'b1;
						state <= awaitHeader;
					end else begin
						chunkId <= chunkId + 1'b1;
					end
				end
				default: state <= awaitHeader;
			endcase
		end
	end

	// Control outputs, one cycle after input
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			SeedValid <= 1'b0;
			SeedIsHeader <= 1'b0;
		end else begin
			SeedValid <= InValid;
			SeedIsHeader <= InValid & isHeader;
		end
	end

	// Payload path, qualified by SeedValid
	always_ff @(posedge Clock) begin
		Seed <= {{oramCryptoPkg::SeedPadWidth{1'b0}}, curIv, bucketId, curChunk};
		SeedFlit <= InData;
	end

endmodule

`default_nettype wire

// ==== cipher/maskCipher.sv ====
// ------------------------------
// Pipelined ARX keyed permutation
// with flit carried alongside
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module maskCipher #(
	parameter int Rounds = 4
) (
	input wire logic Clock,
	input wire logic arstN,
	input wire oramCryptoPkg::keyT Key,
	input wire logic SeedValid,
	input wire oramCryptoPkg::seedT Seed,
	input wire oramCryptoPkg::flitT SeedFlit,
	input wire logic SeedIsHeader,
	output logic MaskValid,
	output oramCryptoPkg::seedT Mask,
	output oramCryptoPkg::flitT MaskFlit,
	output logic MaskIsHeader
);

	localparam int Half = oramCryptoPkg::HalfWidth;
	// Left rotate distance per round
	localparam int RotateBy = 7;

	// One round of add, rotate, xor, swap
	function automatic oramCryptoPkg::seedT roundStep(
		input oramCryptoPkg::seedT word,
		input oramCryptoPkg::halfT keyHalf
	);
		oramCryptoPkg::halfT left;
		oramCryptoPkg::halfT right;
		left = word[2*Half-1:Half] + keyHalf;
		left = {left[Half-RotateBy-1:0], left[Half-1:Half-RotateBy]};
		right = word[Half-1:0] ^ left;
		// Halves swap on the way out
		return {right, left};
	endfunction

	// ------------------------------
	// Stage registers
	// ------------------------------

	oramCryptoPkg::seedT stageWord [Rounds];
	oramCryptoPkg::flitT stageFlit [Rounds];
	logic stageValid [Rounds];
	logic stageHeader [Rounds];

	for (genvar s = 0; s < Rounds; s++) begin : gRound
		oramCryptoPkg::seedT wordIn;
		oramCryptoPkg::flitT flitIn;
		oramCryptoPkg::halfT keyHalf;
		logic validIn;
		logic headerIn;

		// Even stages use the low key half
		if (s % 2 == 0) begin : gEven
			assign keyHalf = Key[Half-1:0];
		end else begin : gOdd
			assign keyHalf = Key[2*Half-1:Half];
		end

		if (s == 0) begin : gFirst
			assign wordIn = Seed;
			assign flitIn = SeedFlit;
			assign validIn = SeedValid;
			assign headerIn = SeedIsHeader;
		end else begin : gNext
			assign wordIn = stageWord[s-1];
			assign flitIn = stageFlit[s-1];
			assign validIn = stageValid[s-1];
			assign headerIn = stageHeader[s-1];
		end

		always_ff @(posedge Clock or negedge arstN) begin
			if (!arstN) begin
				stageValid[s] <= 1'b0;
				stageHeader[s] <= 1'b0;
			end else begin
				stageValid[s] <= validIn;
				stageHeader[s] <= headerIn;
			end
		end

		// Never stalls, every stage moves each cycle
		always_ff @(posedge Clock) begin
			stageWord[s] <= roundStep(wordIn, keyHalf);
			stageFlit[s] <= flitIn;
		end
	end

	// Last stage feeds the queue
	assign MaskValid = stageValid[Rounds-1];
	assign Mask = stageWord[Rounds-1];
	assign MaskFlit = stageFlit[Rounds-1];
	assign MaskIsHeader = stageHeader[Rounds-1];

endmodule

`default_nettype wire

// ==== logic/outputQueue.sv ====
// ------------------------------
// Mask combine, output queue and
// credit handling on both sides
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module outputQueue #(
	parameter int QueueDepth = 8,
	parameter int OutCredits = 2
) (
	input wire logic Clock,
	input wire logic arstN,
	input wire logic Enable,
	input wire logic MaskValid,
	input wire oramCryptoPkg::seedT Mask,
	input wire oramCryptoPkg::flitT MaskFlit,
	input wire logic MaskIsHeader,
	input wire logic OutCredit,
	output logic OutValid,
	output oramCryptoPkg::flitT OutData,
	output logic InCredit
);

	localparam int PtrWidth = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
	localparam int FillWidth = $clog2(QueueDepth + 1);
	localparam int CreditWidth = $clog2(OutCredits + 1);

	typedef logic [PtrWidth-1:0] ptrT;
	typedef logic [FillWidth-1:0] fillT;
	typedef logic [CreditWidth-1:0] creditT;

	// Circular buffer storage
	oramCryptoPkg::flitT mem [QueueDepth];
	ptrT wrPtr;
	ptrT rdPtr;
	fillT fill;
	// Credits held toward downstream
	creditT credits;

	oramCryptoPkg::flitT writeData;
	logic push;
	logic pop;

	// ------------------------------
	// Combine
	// ------------------------------

	// Headers and disabled mode pass plain
	assign writeData = (MaskIsHeader || !Enable) ? MaskFlit : MaskFlit ^ Mask;
	assign push = MaskValid;
	// Send only with a credit and something queued
	assign pop = (credits != '0) && (fill != '0);

	always_ff @(posedge Clock) begin
		if (push) begin
			mem[wrPtr] <= writeData;
		end
	end

	// ------------------------------
	// Pointers and counts
	// ------------------------------

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			fill <= '0;
			credits <= creditT'(OutCredits);
		end else begin
			if (push) begin
				wrPtr <= (wrPtr == ptrT'(QueueDepth - 1)) ? '0 : wrPtr + 1'b1;
			end
			if (pop) begin
				rdPtr <= (rdPtr == ptrT'(QueueDepth - 1)) ? '0 : rdPtr + 1'b1;
			end
			// Upstream credits bound fill to QueueDepth
			fill <= fill + fillT'(push) - fillT'(pop);
			credits <= credits + creditT'(OutCredit) - creditT'(pop);
		end
	end

	// Output strobe and input credit return
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			OutValid <= 1'b0;
			InCredit <= 1'b0;
		end else begin
			OutValid <= pop;
			InCredit <= pop;
		end
	end

	always_ff @(posedge Clock) begin
		OutData <= mem[rdPtr];
	end

endmodule

`default_nettype wire

// ==== logic/oramCryptFilter.sv ====
// ------------------------------
// Crypto filter top level
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module oramCryptFilter #(
	parameter int BucketFlits = 4,
	parameter int PathBuckets = 3,
	parameter int Rounds = 4,
	parameter int QueueDepth = 8,
	parameter int OutCredits = 2
) (
	input wire logic Clock,
	input wire logic arstN,
	input wire logic CfgWrite,
	input wire oramCryptoPkg::cfgAddrT CfgAddr,
	input wire oramCryptoPkg::cfgDataT CfgData,
	input wire logic InValid,
	input wire oramCryptoPkg::flitT InData,
	output logic InCredit,
	output logic OutValid,
	output oramCryptoPkg::flitT OutData,
	input wire logic OutCredit
);

	// Config outputs
	oramCryptoPkg::keyT key;
	logic enable;

	// Seed stage to cipher
	logic seedValid;
	oramCryptoPkg::seedT seed;
	oramCryptoPkg::flitT seedFlit;
	logic seedIsHeader;

	// Cipher to queue
	logic maskValid;
	oramCryptoPkg::seedT mask;
	oramCryptoPkg::flitT maskFlit;
	logic maskIsHeader;

	cryptoConfig u_cryptoConfig (
		.Clock(Clock), .arstN(arstN),
		.CfgWrite(CfgWrite), .CfgAddr(CfgAddr), .CfgData(CfgData),
		.Key(key), .Enable(enable)
	);

	seedGen #(.BucketFlits(BucketFlits), .PathBuckets(PathBuckets)) u_seedGen (
		.Clock(Clock), .arstN(arstN),
		.InValid(InValid), .InData(InData),
		.SeedValid(seedValid), .Seed(seed), .SeedFlit(seedFlit), .SeedIsHeader(seedIsHeader)
	);

	maskCipher #(.Rounds(Rounds)) u_maskCipher (
		.Clock(Clock), .arstN(arstN), .Key(key),
		.SeedValid(seedValid), .Seed(seed), .SeedFlit(seedFlit), .SeedIsHeader(seedIsHeader),
		.MaskValid(maskValid), .Mask(mask), .MaskFlit(maskFlit), .MaskIsHeader(maskIsHeader)
	);

	outputQueue #(.QueueDepth(QueueDepth), .OutCredits(OutCredits)) u_outputQueue (
		.Clock(Clock), .arstN(arstN), .Enable(enable),
		.MaskValid(maskValid), .Mask(mask), .MaskFlit(maskFlit), .MaskIsHeader(maskIsHeader),
		.OutCredit(OutCredit), .OutValid(OutValid), .OutData(OutData), .InCredit(InCredit)
	);

endmodule

`default_nettype wire

// ==== test/clockGen.sv ====
// ------------------------------
// Testbench clock and reset
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module clockGen #(
	parameter int HalfPeriod = 20,
	parameter int ResetCycles = 16
) (
	output logic Clock,
	output logic arstN
);

	initial begin
		Clock = 1'b0;
		forever #HalfPeriod Clock = ~Clock;
	end

	// Release on a falling edge, clear of the rising edge
	initial begin
		arstN = 1'b0;
		repeat (ResetCycles) @(negedge Clock);
		arstN = 1'b1;
	end

endmodule

`default_nettype wire

// ==== test/oramCryptFilterTb.sv ====
// ------------------------------
// Vector driven testbench for the
// crypto filter with credit handling
// ------------------------------
`timescale 1ns/1ns
`default_nettype none

module oramCryptFilterTb;

	localparam int BucketFlits = 4;
	localparam int PathBuckets = 3;
	localparam int Rounds = 4;
	localparam int QueueDepth = 8;
	localparam int OutCredits = 2;
	// One header word plus four records of 4 + 2*12 words
	localparam int VecWords = 113;
	localparam int TestTimeout = 2000;
	localparam int StarveLimit = 50;
	localparam int HoldCycles = 40;
	localparam int ResetTimeout = 100;

	logic Clock;
	logic arstN;
	logic CfgWrite;
	oramCryptoPkg::cfgAddrT CfgAddr;
	oramCryptoPkg::cfgDataT CfgData;
	logic InValid;
	oramCryptoPkg::flitT InData;
	logic InCredit;
	logic OutValid;
	oramCryptoPkg::flitT OutData;
	logic OutCredit;

	logic [63:0] vec [0:VecWords-1];

	// Monitor owned
	oramCryptoPkg::flitT outQ [$];
	longint outTime [$];
	int outCount = 0;
	int inCreditPulses = 0;

	// Driver owned
	int totalSent = 0;
	int totalReturned = 0;
	int errors = 0;
	int testsPassed = 0;
	int testsFailed = 0;

	clockGen u_clockGen (.Clock(Clock), .arstN(arstN));

	oramCryptFilter #(
		.BucketFlits(BucketFlits),
		.PathBuckets(PathBuckets),
		.Rounds(Rounds),
		.QueueDepth(QueueDepth),
		.OutCredits(OutCredits)
	) u_oramCryptFilter (
		.Clock(Clock), .arstN(arstN),
		.CfgWrite(CfgWrite), .CfgAddr(CfgAddr), .CfgData(CfgData),
		.InValid(InValid), .InData(InData), .InCredit(InCredit),
		.OutValid(OutValid), .OutData(OutData), .OutCredit(OutCredit)
	);

	// ------------------------------
	// Output monitor
	// ------------------------------

	// Rising edge sees the values of the previous cycle
	always @(posedge Clock) begin
		if (arstN) begin
			if (OutValid) begin
				outQ.push_back(OutData);
				outTime.push_back($time);
				outCount++;
			end
			if (InCredit) begin
				inCreditPulses++;
			end
		end
	end

	task automatic writeConfig(
		input oramCryptoPkg::cfgAddrT addr,
		input oramCryptoPkg::cfgDataT data
	);
		@(negedge Clock);
		CfgWrite = 1'b1;
		CfgAddr = addr;
		CfgData = data;
		@(negedge Clock);
		CfgWrite = 1'b0;
	endtask

	// Configure, stream, drain and compare one record
	task automatic runTest(input int recBase, input int testNum);
		logic [63:0] mode;
		logic [63:0] key;
		int count;
		int base;
		int sent;
		int cycles;
		int starve;
		int testErrors;
		int avail;
		logic holding;
		mode = vec[recBase];
		key = vec[recBase+1];
		count = int'(vec[recBase+3][31:0]);
		base = outCount;
		sent = 0;
		cycles = 0;
		starve = 0;
		testErrors = 0;
		writeConfig(oramCryptoPkg::CfgKeyLow, key[31:0]);
		writeConfig(oramCryptoPkg::CfgKeyHigh, key[63:32]);
		writeConfig(oramCryptoPkg::CfgControl, {31'd0, vec[recBase+2][0]});
		while ((outCount - base < count) && (cycles < TestTimeout) && (testErrors == 0)) begin
			@(negedge Clock);
			cycles++;
			InValid = 1'b0;
			OutCredit = 1'b0;
			holding = (mode[0] == 1'b1) && (cycles < HoldCycles);
			avail = QueueDepth - totalSent + inCreditPulses;
			if (sent < count && avail > 0) begin
				InValid = 1'b1;
				InData = vec[recBase+4+2*sent];
				sent++;
				totalSent++;
			end
			// Give a credit back per flit taken unless held
			if (!holding && outCount > totalReturned) begin
				OutCredit = 1'b1;
				totalReturned++;
			end
			if (holding && (outCount - base > OutCredits)) begin
				$display("Test %0d: %0d flits came out with credits withheld, limit %0d",
					testNum, outCount - base, OutCredits);
				testErrors++;
			end
			if (sent < count && avail == 0 && !holding) begin
				starve++;
			end else begin
				starve = 0;
			end
			if (starve > StarveLimit) begin
				$display("Test %0d: input credits did not return within %0d cycles",
					testNum, StarveLimit);
				testErrors++;
			end
		end
		if (cycles >= TestTimeout) begin
			$display("Test %0d: timed out with %0d of %0d flits out",
				testNum, outCount - base, count);
			testErrors++;
		end
		// Drain and return the remaining credits
		cycles = 0;
		while (cycles < Rounds + 6) begin
			@(negedge Clock);
			cycles++;
			InValid = 1'b0;
			OutCredit = 1'b0;
			if (outCount > totalReturned) begin
				OutCredit = 1'b1;
				totalReturned++;
			end
		end
		@(negedge Clock);
		OutCredit = 1'b0;
		if (outCount - base != count) begin
			$display("Test %0d: expected %0d output flits, saw %0d",
				testNum, count, outCount - base);
			testErrors++;
		end
		for (int i = 0; i < count && base + i < outCount; i++) begin
			if (outQ[base+i] !== vec[recBase+5+2*i]) begin
				$display("Error at %0t ns: OutData flit %0d got %h expected %h",
					outTime[base+i], i, outQ[base+i], vec[recBase+5+2*i]);
				testErrors++;
			end
		end
		errors += testErrors;
		if (testErrors == 0) begin
			testsPassed++;
			$display("Test %0d passed, %0d flits", testNum, count);
		end else begin
			testsFailed++;
			$display("Test %0d failed, %0d errors", testNum, testErrors);
		end
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------

	initial begin
		int numTests;
		int recBase;
		int waited;
		CfgWrite = 1'b0;
		CfgAddr = '0;
		CfgData = '0;
		InValid = 1'b0;
		InData = '0;
		OutCredit = 1'b0;
		$readmemh("test/cryptVectors.txt", vec);
		numTests = int'(vec[0][31:0]);
		waited = 0;
		while (arstN !== 1'b1 && waited < ResetTimeout) begin
			@(negedge Clock);
			waited++;
		end
		if (arstN !== 1'b1) begin
			$display("Reset never released");
			errors++;
		end else if (numTests < 1) begin
			$display("Vector file holds no tests");
			errors++;
		end else begin
			recBase = 1;
			for (int t = 1; t <= numTests; t++) begin
				runTest(recBase, t);
				recBase += 4 + 2 * int'(vec[recBase+3][31:0]);
			end
		end
		// Every popped flit returns one input credit
		if (inCreditPulses != outCount) begin
			$display("Error at %0t ns: InCredit pulses got %0d expected %0d",
				$time, inCreditPulses, outCount);
			errors++;
		end
		$display("Tests passed %0d, failed %0d, errors %0d", testsPassed, testsFailed, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== test/cryptVectors.txt ====
// Word 0 test count; each test: mode(1 = withhold credits) key enable flitCount,
// then flitCount lines of input flit and expected output flit
4
// Full path, key zero, enabled
0 0000000000000000 1 c
A5A5A5A500000011 A5A5A5A500000011
FFFFFFFF00000000 FFDFFDDF40204224
FFFFFFFF00000000 FFBFFDDF40408224
FFFFFFFF00000000 FF9FFDDF4060C224
5A5A5A5A00000022 5A5A5A5A00000022
FFFFFFFF00000000 DFDFFBBFA0604448
FFFFFFFF00000000 DFBFFBBFA0008448
FFFFFFFF00000000 DF9FFBBFA020C448
C3C3C3C300000033 C3C3C3C300000033
FFFFFFFF00000000 BFDFF99F80A0466C
FFFFFFFF00000000 BFBFF99F80C0866C
FFFFFFFF00000000 BF9FF99F80E0C66C
// Disabled, every flit passes
0 0123456789ABCDEF 0 c
A5A5A5A500000011 A5A5A5A500000011
1111111111111111 1111111111111111
2222222222222222 2222222222222222
3333333333333333 3333333333333333
5A5A5A5A00000022 5A5A5A5A00000022
4444444444444444 4444444444444444
5555555555555555 5555555555555555
6666666666666666 6666666666666666
C3C3C3C300000033 C3C3C3C300000033
7777777777777777 7777777777777777
8888888888888888 8888888888888888
9999999999999999 9999999999999999
// Round trip of the first path
0 0000000000000000 1 c
A5A5A5A500000011 A5A5A5A500000011
FFDFFDDF40204224 FFFFFFFF00000000
FFBFFDDF40408224 FFFFFFFF00000000
FF9FFDDF4060C224 FFFFFFFF00000000
5A5A5A5A00000022 5A5A5A5A00000022
DFDFFBBFA0604448 FFFFFFFF00000000
DFBFFBBFA0008448 FFFFFFFF00000000
DF9FFBBFA020C448 FFFFFFFF00000000
C3C3C3C300000033 C3C3C3C300000033
BFDFF99F80A0466C FFFFFFFF00000000
BFBFF99F80C0866C FFFFFFFF00000000
BF9FF99F80E0C66C FFFFFFFF00000000
// First path again with output credits withheld
1 0000000000000000 1 c
A5A5A5A500000011 A5A5A5A500000011
FFFFFFFF00000000 FFDFFDDF40204224
FFFFFFFF00000000 FFBFFDDF40408224
FFFFFFFF00000000 FF9FFDDF4060C224
5A5A5A5A00000022 5A5A5A5A00000022
FFFFFFFF00000000 DFDFFBBFA0604448
FFFFFFFF00000000 DFBFFBBFA0008448
FFFFFFFF00000000 DF9FFBBFA020C448
C3C3C3C300000033 C3C3C3C300000033
FFFFFFFF00000000 BFDFF99F80A0466C
FFFFFFFF00000000 BFBFF99F80C0866C
FFFFFFFF00000000 BF9FF99F80E0C66C

// ==== flist.f ====
common/oramCryptoPkg.sv
logic/cryptoConfig.sv
logic/seedGen.sv
cipher/maskCipher.sv
logic/outputQueue.sv
logic/oramCryptFilter.sv
test/clockGen.sv
test/oramCryptFilterTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the crypto filter testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module oramCryptFilterTb -f flist.f -o simv

./obj_dir/simv | tee sim.log

if grep -q "Finished with no errors" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi
